// File: design/lsu_pkg.sv
package lsu_pkg;

  // cache geometry
  localparam int WAY_CNT    = 2;
  localparam int LINE_WORDS = 4;
  localparam int WBUF_DEPTH = 4;
  localparam int LINE_CNT   = 256;

  // bus codes
  localparam logic [3:0] BURST_LINE = 4'd3;
  localparam logic [3:0] BURST_ONE  = 4'd0;
  localparam logic [1:0] WORD_SIZE  = 2'd2;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [3:0]  strobe_t;
  typedef logic [1:0]  size_t;
  typedef logic [19:0] tag_addr_t;
  typedef logic [7:0]  line_idx_t;
  typedef logic [9:0]  dram_addr_t;
  typedef logic [0:0]  way_t;
  typedef logic [WAY_CNT-1:0] way_mask_t;
  typedef logic [1:0]  beat_t;

  typedef struct packed {
    logic      valid;
    tag_addr_t addr;
  } tag_t;

  typedef enum logic {
    OP_REFILL,
    OP_UNCACHED_READ
  } miss_op_e;

  typedef enum logic [2:0] {
    S_IDLE,
    S_WB_ADDR,
    S_WB_DATA,
    S_REFILL_ADDR,
    S_REFILL_DATA,
    S_PT_ADDR,
    S_PT_DATA,
    S_TAG_UPDATE
  } miss_state_e;

  typedef enum logic [1:0] {
    S_EMPTY,
    S_ADDR,
    S_DATA
  } wbuf_state_e;

  typedef struct packed {
    logic                     hit_write;
    way_mask_t                wsel;
    logic                     uncached_write;
    logic                     refill_req;
    logic                     uncached_read;
    addr_t                    addr;
    word_t                    wdata;
    strobe_t                  wstrobe;
    size_t                    size;
    tag_t  [WAY_CNT-1:0]      tag_rdata;
    word_t [WAY_CNT-1:0]      rdata;
  } lsu_req_t;

  typedef struct packed {
    logic       wr_ready;
    logic       op_done;
    logic       read_ready;
    word_t      rdata;
    logic       dram_take_over;
    dram_addr_t data_raddr;
  } lsu_resp_t;

  typedef struct packed {
    logic       valid;
    logic       write;
    logic [3:0] burst_size;
    logic       cached;
    size_t      data_size;
    addr_t      addr;
    logic       data_ok;
    logic       data_last;
    strobe_t    data_strobe;
    word_t      w_data;
  } bus_req_t;

  typedef struct packed {
    logic  ready;
    logic  data_ok;
    logic  data_last;
    word_t r_data;
  } bus_resp_t;

  typedef struct packed {
    dram_addr_t            data_waddr;
    word_t                 data_wdata;
    strobe_t [WAY_CNT-1:0] data_we;
    line_idx_t             tag_waddr;
    tag_t                  tag_wdata;
    way_mask_t             tag_we;
  } wport_req_t;

  function automatic dram_addr_t dram_addr_of(addr_t addr);
    return addr[11:2];
  endfunction

  function automatic line_idx_t line_idx_of(addr_t addr);
    return addr[11:4];
  endfunction

  function automatic tag_addr_t tag_of(addr_t addr);
    return addr[31:12];
  endfunction

  function automatic addr_t line_base_of(addr_t addr);
    return {addr[31:4], 4'b0000};
  endfunction

endpackage

// File: design/dirty_ram.sv
`timescale 1ns/100ps

module dirty_ram (
  input  logic                  clk,
  input  logic                  rst_n,
  input  lsu_pkg::way_mask_t    we_i,
  input  lsu_pkg::line_idx_t    waddr_i,
  input  logic                  wdata_i,
  input  lsu_pkg::line_idx_t    raddr_i,
  output lsu_pkg::way_mask_t    rdata_o
);

  lsu_pkg::way_mask_t bits_q [lsu_pkg::LINE_CNT];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < lsu_pkg::LINE_CNT; i++) begin
        bits_q[i] <= '0;
      end
    end else begin
      for (int w = 0; w < lsu_pkg::WAY_CNT; w++) begin
        if (we_i[w]) begin
          bits_q[waddr_i][w] <= wdata_i;
        end
      end
    end
  end

  // read is asynchronous
  assign rdata_o = bits_q[raddr_i];

endmodule

// File: design/uncached_write_buffer.sv
`timescale 1ns/100ps

module uncached_write_buffer (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                push_i,
  input  lsu_pkg::addr_t      addr_i,
  input  lsu_pkg::word_t      data_i,
  input  lsu_pkg::strobe_t    strobe_i,
  input  lsu_pkg::size_t      size_i,
  output logic                wr_ready_o,
  input  lsu_pkg::bus_resp_t  bus_resp_i,
  output logic                busy_o,
  output lsu_pkg::bus_req_t   bus_req_o
);

  typedef struct packed {
    lsu_pkg::addr_t   addr;
    lsu_pkg::word_t   data;
    lsu_pkg::strobe_t strobe;
    lsu_pkg::size_t   size;
  } entry_t;

  entry_t fifo_q [lsu_pkg::WBUF_DEPTH];
  entry_t incoming;
  entry_t handling_q;

  lsu_pkg::wbuf_state_e state_q, state_d;

  // extra bit tells full from empty
  logic [2:0] wr_ptr_q, rd_ptr_q, count;
  logic       empty, full, accept, load;

  assign incoming = '{addr: addr_i, data: data_i, strobe: strobe_i, size: size_i};
  assign count    = wr_ptr_q - rd_ptr_q;
  assign empty    = (count == 3'd0);
  assign full     = (count == 3'(lsu_pkg::WBUF_DEPTH));
  assign accept   = push_i && !full;

  assign wr_ready_o = !full;
  assign busy_o     = (state_q != lsu_pkg::S_EMPTY);

  always_comb begin
    state_d = state_q;
    case (state_q)
      lsu_pkg::S_ADDR: begin
        if (bus_resp_i.ready) begin
          state_d = lsu_pkg::S_DATA;
        end
      end
      lsu_pkg::S_DATA: begin
        if (bus_resp_i.data_ok) begin
          state_d = (empty && !accept) ? lsu_pkg::S_EMPTY : lsu_pkg::S_ADDR;
        end
      end
      default: begin
        if (accept) begin
          state_d = lsu_pkg::S_ADDR;
        end
      end
    endcase
  end

  // handling register loads on every entry into S_ADDR
  assign load = (state_d == lsu_pkg::S_ADDR) && (state_q != lsu_pkg::S_ADDR);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q  <= lsu_pkg::S_EMPTY;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      state_q <= state_d;
      if (accept && !(load && empty)) begin
        wr_ptr_q <= wr_ptr_q + 3'd1;
      end
      if (load && !empty) begin
        rd_ptr_q <= rd_ptr_q + 3'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept && !(load && empty)) begin
      fifo_q[wr_ptr_q[1:0]] <= incoming;
    end
    if (load) begin
      // empty queue: store goes straight to the bus
      handling_q <= empty ? incoming : fifo_q[rd_ptr_q[1:0]];
    end
  end

  always_comb begin
    bus_req_o             = '0;
    bus_req_o.write       = 1'b1;
    bus_req_o.burst_size  = lsu_pkg::BURST_ONE;
    bus_req_o.data_size   = handling_q.size;
    bus_req_o.addr        = handling_q.addr;
    bus_req_o.data_strobe = handling_q.strobe;
    bus_req_o.w_data      = handling_q.data;
    bus_req_o.valid       = (state_q == lsu_pkg::S_ADDR);
    bus_req_o.data_ok     = (state_q == lsu_pkg::S_DATA);
    bus_req_o.data_last   = (state_q == lsu_pkg::S_DATA);
  end

endmodule

// File: design/miss_handler.sv
`timescale 1ns/100ps

module miss_handler (
  input  logic                  clk,
  input  logic                  rst_n,
  input  lsu_pkg::lsu_req_t     req_i,
  output lsu_pkg::lsu_resp_t    resp_o,
  input  lsu_pkg::way_mask_t    dirty_i,
  output lsu_pkg::line_idx_t    dirty_raddr_o,
  input  logic                  bus_busy_i,
  input  lsu_pkg::bus_resp_t    bus_resp_i,
  output lsu_pkg::bus_req_t     bus_req_o,
  output lsu_pkg::miss_state_e  state_o,
  output lsu_pkg::way_t         victim_o,
  output lsu_pkg::dram_addr_t   refill_waddr_o
);

  lsu_pkg::miss_state_e state_q, state_d;
  lsu_pkg::miss_op_e    op_q;
  lsu_pkg::addr_t       op_addr_q;
  lsu_pkg::size_t       op_size_q;
  lsu_pkg::tag_t        oldtag_q;
  lsu_pkg::way_t        rr_q, next_way;
  logic                 op_valid_q, done_q, capture;

  // writeback read pipeline and buffer
  logic                 rd_active_q, fill_valid_q;
  lsu_pkg::beat_t       rd_ptr_q, fill_ptr_q, wb_beat_q, refill_beat_q;
  lsu_pkg::word_t       wb_buf_q [lsu_pkg::LINE_WORDS];
  logic [lsu_pkg::LINE_WORDS-1:0] wb_valid_q;
  logic                 wb_send, wb_start;
  lsu_pkg::line_idx_t   op_idx;

  assign next_way = rr_q + 1'b1;
  assign op_idx   = lsu_pkg::line_idx_of(op_addr_q);
  assign capture  = (state_q == lsu_pkg::S_IDLE) && !op_valid_q && !done_q &&
                    (req_i.refill_req || req_i.uncached_read);
  assign wb_send  = (state_q == lsu_pkg::S_WB_DATA) && wb_valid_q[wb_beat_q];
  assign wb_start = (state_q == lsu_pkg::S_IDLE) && (state_d == lsu_pkg::S_WB_ADDR);

  always_comb begin
    state_d = state_q;
    case (state_q)
      lsu_pkg::S_IDLE: begin
        if (op_valid_q && !bus_busy_i) begin
          if (op_q == lsu_pkg::OP_UNCACHED_READ) begin
            state_d = lsu_pkg::S_PT_ADDR;
          end else begin
            state_d = dirty_i[rr_q] ? lsu_pkg::S_WB_ADDR : lsu_pkg::S_REFILL_ADDR;
          end
        end
      end
      lsu_pkg::S_WB_ADDR: begin
        if (bus_resp_i.ready && !bus_busy_i) state_d = lsu_pkg::S_WB_DATA;
      end
      lsu_pkg::S_WB_DATA: begin
        if (wb_send && bus_resp_i.data_ok && wb_beat_q == 2'd3) begin
          state_d = lsu_pkg::S_REFILL_ADDR;
        end
      end
      lsu_pkg::S_REFILL_ADDR: begin
        if (bus_resp_i.ready && !bus_busy_i) state_d = lsu_pkg::S_REFILL_DATA;
      end
      lsu_pkg::S_REFILL_DATA: begin
        if (bus_resp_i.data_ok && bus_resp_i.data_last) state_d = lsu_pkg::S_TAG_UPDATE;
      end
      lsu_pkg::S_PT_ADDR: begin
        if (bus_resp_i.ready && !bus_busy_i) state_d = lsu_pkg::S_PT_DATA;
      end
      lsu_pkg::S_PT_DATA: begin
        if (bus_resp_i.data_ok && bus_resp_i.data_last) state_d = lsu_pkg::S_IDLE;
      end
      default: state_d = lsu_pkg::S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q      <= lsu_pkg::S_IDLE;
      op_valid_q   <= 1'b0;
      done_q       <= 1'b0;
      rr_q         <= '0;
      rd_active_q  <= 1'b0;
      fill_valid_q <= 1'b0;
      wb_valid_q   <= '0;
    end else begin
      state_q      <= state_d;
      done_q       <= (state_q != lsu_pkg::S_IDLE) && (state_d == lsu_pkg::S_IDLE);
      fill_valid_q <= rd_active_q;
      if (capture) begin
        op_valid_q <= 1'b1;
      end else if (state_q == lsu_pkg::S_IDLE && state_d != lsu_pkg::S_IDLE) begin
        op_valid_q <= 1'b0;
      end
      if (capture && req_i.refill_req) begin
        rr_q <= next_way;
      end
      if (wb_start) begin
        rd_active_q <= 1'b1;
        wb_valid_q  <= '0;
      end else begin
        if (rd_active_q && rd_ptr_q == 2'd3) rd_active_q <= 1'b0;
        if (fill_valid_q) wb_valid_q[fill_ptr_q] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      op_q      <= req_i.refill_req ? lsu_pkg::OP_REFILL : lsu_pkg::OP_UNCACHED_READ;
      op_addr_q <= req_i.addr;
      op_size_q <= req_i.size;
      oldtag_q  <= req_i.tag_rdata[next_way];
    end
    fill_ptr_q <= rd_ptr_q;
    // pipe rdata lags data_raddr by one cycle
    if (fill_valid_q) wb_buf_q[fill_ptr_q] <= req_i.rdata[rr_q];
    if (wb_start) begin
      rd_ptr_q  <= '0;
      wb_beat_q <= '0;
    end else begin
      if (rd_active_q) rd_ptr_q <= rd_ptr_q + 2'd1;
      if (wb_send && bus_resp_i.data_ok) wb_beat_q <= wb_beat_q + 2'd1;
    end
    if (state_q != lsu_pkg::S_REFILL_DATA) begin
      refill_beat_q <= '0;
    end else if (bus_resp_i.data_ok) begin
      refill_beat_q <= refill_beat_q + 2'd1;
    end
  end

  assign state_o        = state_q;
  assign victim_o       = rr_q;
  assign dirty_raddr_o  = op_idx;
  assign refill_waddr_o = {op_idx, refill_beat_q};

  always_comb begin
    resp_o                = '0;
    resp_o.op_done        = done_q;
    resp_o.rdata          = bus_resp_i.r_data;
    resp_o.dram_take_over = rd_active_q;
    resp_o.data_raddr     = {op_idx, rd_ptr_q};
    resp_o.read_ready     = bus_resp_i.data_ok &&
                            ((state_q == lsu_pkg::S_REFILL_DATA &&
                              refill_beat_q == op_addr_q[3:2]) ||
                             state_q == lsu_pkg::S_PT_DATA);
  end

  always_comb begin
    bus_req_o             = '0;
    bus_req_o.burst_size  = lsu_pkg::BURST_LINE;
    bus_req_o.data_size   = lsu_pkg::WORD_SIZE;
    bus_req_o.addr        = lsu_pkg::line_base_of(op_addr_q);
    bus_req_o.data_strobe = '1;
    bus_req_o.w_data      = wb_buf_q[wb_beat_q];
    case (state_q)
      lsu_pkg::S_WB_ADDR: begin
        bus_req_o.valid = 1'b1;
        bus_req_o.write = 1'b1;
        bus_req_o.addr  = {oldtag_q.addr, op_idx, 4'b0000};
      end
      lsu_pkg::S_WB_DATA: begin
        bus_req_o.write     = 1'b1;
        bus_req_o.data_ok   = wb_send;
        bus_req_o.data_last = (wb_beat_q == 2'd3);
      end
      lsu_pkg::S_REFILL_ADDR: bus_req_o.valid = 1'b1;
      lsu_pkg::S_PT_ADDR: begin
        bus_req_o.valid      = 1'b1;
        bus_req_o.burst_size = lsu_pkg::BURST_ONE;
        bus_req_o.data_size  = op_size_q;
        bus_req_o.addr       = op_addr_q;
      end
      lsu_pkg::S_PT_DATA: bus_req_o.burst_size = lsu_pkg::BURST_ONE;
      default: bus_req_o.valid = 1'b0;
    endcase
  end

endmodule

// File: design/cache_write_port.sv
`timescale 1ns/100ps

module cache_write_port (
  input  lsu_pkg::lsu_req_t     req_i,
  input  lsu_pkg::miss_state_e  state_i,
  input  lsu_pkg::way_t         victim_i,
  input  lsu_pkg::dram_addr_t   refill_waddr_i,
  input  lsu_pkg::bus_resp_t    bus_resp_i,
  output lsu_pkg::wport_req_t   wport_o,
  output lsu_pkg::way_mask_t    dirty_we_o,
  output lsu_pkg::line_idx_t    dirty_waddr_o,
  output logic                  dirty_wdata_o
);

  lsu_pkg::line_idx_t op_idx;

  // index of the line under refill
  assign op_idx = refill_waddr_i[9:2];

  always_comb begin
    wport_o            = '0;
    wport_o.data_waddr = lsu_pkg::dram_addr_of(req_i.addr);
    wport_o.data_wdata = req_i.wdata;
    wport_o.tag_waddr  = op_idx;
    wport_o.tag_wdata  = '{valid: 1'b1, addr: lsu_pkg::tag_of(req_i.addr)};
    dirty_we_o         = '0;
    dirty_waddr_o      = lsu_pkg::line_idx_of(req_i.addr);
    dirty_wdata_o      = 1'b1;

    case (state_i)
      lsu_pkg::S_IDLE: begin
        // hit store, mark the line dirty
        if (req_i.hit_write) begin
          for (int w = 0; w < lsu_pkg::WAY_CNT; w++) begin
            wport_o.data_we[w] = req_i.wsel[w] ? req_i.wstrobe : '0;
          end
          dirty_we_o = req_i.wsel;
        end
      end
      lsu_pkg::S_REFILL_DATA: begin
        if (bus_resp_i.data_ok) begin
          wport_o.data_we[victim_i] = '1;
          wport_o.data_waddr        = refill_waddr_i;
          wport_o.data_wdata        = bus_resp_i.r_data;
        end
      end
      lsu_pkg::S_TAG_UPDATE: begin
        wport_o.tag_we[victim_i] = 1'b1;
        dirty_we_o[victim_i]     = 1'b1;
        dirty_waddr_o            = op_idx;
        dirty_wdata_o            = 1'b0;
      end
      default: dirty_wdata_o = 1'b1;
    endcase
  end

endmodule

// File: design/bus_request_mux.sv
`timescale 1ns/100ps

module bus_request_mux (
  input  logic               wbuf_busy_i,
  input  lsu_pkg::bus_req_t  wbuf_req_i,
  input  lsu_pkg::bus_req_t  miss_req_i,
  output lsu_pkg::bus_req_t  bus_req_o
);

  logic line_burst;

  // only line bursts of the miss side go out cached
  assign line_burst = (miss_req_i.burst_size == lsu_pkg::BURST_LINE);

  always_comb begin
    if (wbuf_busy_i) begin
      // uncached stores own the bus until drained
      bus_req_o        = wbuf_req_i;
      bus_req_o.cached = 1'b0;
    end else begin
      bus_req_o        = miss_req_i;
      bus_req_o.cached = line_burst;
    end
  end

endmodule

// File: design/lsu_wport.sv
`timescale 1ns/100ps

module lsu_wport (
  input  logic                 clk,
  input  logic                 rst_n,
  input  lsu_pkg::lsu_req_t    req_i,
  output lsu_pkg::lsu_resp_t   resp_o,
  output lsu_pkg::wport_req_t  wport_o,
  output lsu_pkg::bus_req_t    bus_req_o,
  input  lsu_pkg::bus_resp_t   bus_resp_i
);

  lsu_pkg::lsu_resp_t   miss_resp;
  lsu_pkg::bus_req_t    wbuf_req, miss_req;
  lsu_pkg::miss_state_e miss_state;
  lsu_pkg::way_t        victim;
  lsu_pkg::dram_addr_t  refill_waddr;
  lsu_pkg::way_mask_t   dirty_we, dirty_rdata;
  lsu_pkg::line_idx_t   dirty_waddr, dirty_raddr;
  logic                 dirty_wdata, wr_ready, wbuf_busy;

  always_comb begin
    resp_o          = miss_resp;
    resp_o.wr_ready = wr_ready;
  end

  dirty_ram u_dirty_ram (
    .clk     (clk),
    .rst_n   (rst_n),
    .we_i    (dirty_we),
    .waddr_i (dirty_waddr),
    .wdata_i (dirty_wdata),
    .raddr_i (dirty_raddr),
    .rdata_o (dirty_rdata)
  );

  uncached_write_buffer u_wbuf (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_i     (req_i.uncached_write),
    .addr_i     (req_i.addr),
    .data_i     (req_i.wdata),
    .strobe_i   (req_i.wstrobe),
    .size_i     (req_i.size),
    .wr_ready_o (wr_ready),
    .bus_resp_i (bus_resp_i),
    .busy_o     (wbuf_busy),
    .bus_req_o  (wbuf_req)
  );

  miss_handler u_miss (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .resp_o         (miss_resp),
    .dirty_i        (dirty_rdata),
    .dirty_raddr_o  (dirty_raddr),
    .bus_busy_i     (wbuf_busy),
    .bus_resp_i     (bus_resp_i),
    .bus_req_o      (miss_req),
    .state_o        (miss_state),
    .victim_o       (victim),
    .refill_waddr_o (refill_waddr)
  );

  cache_write_port u_wport (
    .req_i          (req_i),
    .state_i        (miss_state),
    .victim_i       (victim),
    .refill_waddr_i (refill_waddr),
    .bus_resp_i     (bus_resp_i),
    .wport_o        (wport_o),
    .dirty_we_o     (dirty_we),
    .dirty_waddr_o  (dirty_waddr),
    .dirty_wdata_o  (dirty_wdata)
  );

  bus_request_mux u_bus_mux (
    .wbuf_busy_i (wbuf_busy),
    .wbuf_req_i  (wbuf_req),
    .miss_req_i  (miss_req),
    .bus_req_o   (bus_req_o)
  );

endmodule

// File: testbench/tb_lsu_wport.sv
`timescale 1ns/100ps

module tb_lsu_wport;

  localparam int CLK_NS = 10;
  // refill 4 + writeback 4 + refill 4 + stores 3 + uncached read 1 + store/refill 5
  localparam int BUS_BEATS = 21;
  localparam int TIMEOUT_NS = 40 * BUS_BEATS * CLK_NS + 2000;

  localparam lsu_pkg::word_t RDATA_K = 32'h5a5a0000;
  localparam lsu_pkg::word_t WAY0_K  = 32'h0f000000;
  localparam lsu_pkg::word_t WAY1_K  = 32'h00f00000;

  typedef struct packed {
    logic                 write;
    logic [3:0]           burst;
    logic                 cached;
    lsu_pkg::size_t       size;
    lsu_pkg::addr_t       addr;
    lsu_pkg::strobe_t     strobe;
    logic                 last_ok;
    lsu_pkg::word_t [3:0] data;
  } bus_txn_t;

  typedef struct packed {
    lsu_pkg::way_mask_t way;
    lsu_pkg::dram_addr_t waddr;
    lsu_pkg::word_t      wdata;
    lsu_pkg::strobe_t    strobe;
  } dwrite_t;

  typedef struct packed {
    lsu_pkg::way_mask_t we;
    lsu_pkg::line_idx_t waddr;
    lsu_pkg::tag_t      wdata;
  } twrite_t;

  logic clk;
  logic rst_n;

  lsu_pkg::lsu_req_t   pipe_req, dut_req;
  lsu_pkg::word_t [1:0] model_rdata;
  lsu_pkg::lsu_resp_t  resp;
  lsu_pkg::wport_req_t wport;
  lsu_pkg::bus_req_t   bus_req;
  lsu_pkg::bus_resp_t  bus_resp;
  lsu_pkg::dram_addr_t raddr_s;

  bus_txn_t            bus_log[$];
  dwrite_t             dwr_log[$];
  twrite_t             tag_log[$];
  lsu_pkg::word_t      rr_log[$];
  lsu_pkg::dram_addr_t take_log[$];

  int errors;
  int tests_run;
  int tests_failed;

  always_comb begin
    dut_req       = pipe_req;
    dut_req.rdata = model_rdata;
  end

  lsu_wport DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_i      (dut_req),
    .resp_o     (resp),
    .wport_o    (wport),
    .bus_req_o  (bus_req),
    .bus_resp_i (bus_resp)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("watchdog: the run did not finish in time");
    $display("*** FAILED ***");
    $finish;
  end

  // data RAM model, word is one cycle behind data_raddr
  always @(negedge clk) begin
    raddr_s <= resp.data_raddr;
  end

  always @(posedge clk) begin
    #1;
    model_rdata[0] = 32'(raddr_s) ^ WAY0_K;
    model_rdata[1] = 32'(raddr_s) ^ WAY1_K;
  end

  always @(negedge clk) begin : write_monitor
    dwrite_t dw;
    twrite_t tw;
    if (rst_n) begin
      for (int w = 0; w < 2; w++) begin
        if (wport.data_we[w] != '0) begin
          dw.way    = 2'b01 << w;
          dw.waddr  = wport.data_waddr;
          dw.wdata  = wport.data_wdata;
          dw.strobe = wport.data_we[w];
          dwr_log.push_back(dw);
        end
      end
      if (wport.tag_we != '0) begin
        tw.we    = wport.tag_we;
        tw.waddr = wport.tag_waddr;
        tw.wdata = wport.tag_wdata;
        tag_log.push_back(tw);
      end
      if (resp.read_ready) begin
        rr_log.push_back(resp.rdata);
      end
      if (resp.dram_take_over) begin
        take_log.push_back(resp.data_raddr);
      end
    end
  end

  // bus slave: random address delay, read beats with gaps
  initial begin : responder
    bus_txn_t t;
    int beats;
    lsu_pkg::addr_t beat_addr;
    bus_resp = '0;
    forever begin
      @(negedge clk);
      if (rst_n && bus_req.valid) begin
        t        = '0;
        t.write  = bus_req.write;
        t.burst  = bus_req.burst_size;
        t.cached = bus_req.cached;
        t.size   = bus_req.data_size;
        t.addr   = bus_req.addr;
        t.strobe = bus_req.data_strobe;
        t.last_ok = 1'b1;
        repeat ($urandom_range(3, 0)) @(posedge clk);
        @(posedge clk);
        #1 bus_resp.ready = 1'b1;
        @(posedge clk);
        #1 bus_resp.ready = 1'b0;
        beats = (t.burst == lsu_pkg::BURST_LINE) ? 4 : 1;
        for (int i = 0; i < beats; i++) begin
          if (t.write) begin
            do @(negedge clk); while (!bus_req.data_ok);
            t.data[i] = bus_req.w_data;
            if (bus_req.data_last != (i == beats - 1)) t.last_ok = 1'b0;
            @(posedge clk);
            #1 bus_resp.data_ok = 1'b1;
          end else begin
            repeat ($urandom_range(1, 0)) @(posedge clk);
            beat_addr = (beats == 4) ? t.addr + 32'(4 * i) : t.addr;
            t.data[i] = beat_addr ^ RDATA_K;
            @(posedge clk);
            #1;
            bus_resp.data_ok   = 1'b1;
            bus_resp.r_data    = t.data[i];
            bus_resp.data_last = (i == beats - 1);
          end
          @(posedge clk);
          #1;
          bus_resp.data_ok   = 1'b0;
          bus_resp.data_last = 1'b0;
        end
        bus_log.push_back(t);
      end
    end
  end

  task automatic report_failure(string msg);
    $display("%0t: %s", $time, msg);
    errors++;
  endtask

  task automatic check_count(string what, int got, int exp);
    if (got != exp) begin
      $display("%0t: saw %0d %s, expected %0d", $time, got, what, exp);
      errors++;
    end
  endtask

  task automatic check_word(string name, lsu_pkg::word_t got, lsu_pkg::word_t exp);
    if (got !== exp) begin
      $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_addr(string name, lsu_pkg::addr_t got, lsu_pkg::addr_t exp);
    if (got !== exp) begin
      $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_strobe(string name, lsu_pkg::strobe_t got, lsu_pkg::strobe_t exp);
    if (got !== exp) begin
      $display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_mask(string name, lsu_pkg::way_mask_t got, lsu_pkg::way_mask_t exp);
    if (got !== exp) begin
      $display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_size(string name, lsu_pkg::size_t got, lsu_pkg::size_t exp);
    if (got !== exp) begin
      $display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_dram(string name, lsu_pkg::dram_addr_t got, lsu_pkg::dram_addr_t exp);
    if (got !== exp) begin
      $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_index(string name, lsu_pkg::line_idx_t got, lsu_pkg::line_idx_t exp);
    if (got !== exp) begin
      $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_tag(string name, lsu_pkg::tag_t got, lsu_pkg::tag_t exp);
    if (got !== exp) begin
      $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic clear_logs();
    bus_log.delete();
    dwr_log.delete();
    tag_log.delete();
    rr_log.delete();
    take_log.delete();
  endtask

  task automatic finish_test(string name, int e0);
    tests_run++;
    if (errors != e0) begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - e0);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  task automatic hit_store(lsu_pkg::addr_t a, lsu_pkg::word_t d, lsu_pkg::strobe_t s,
                           lsu_pkg::way_mask_t way);
    @(posedge clk);
    #1;
    pipe_req.hit_write = 1'b1;
    pipe_req.wsel      = way;
    pipe_req.addr      = a;
    pipe_req.wdata     = d;
    pipe_req.wstrobe   = s;
    @(negedge clk);
    check_strobe("wport.data_we[0]", wport.data_we[0], way[0] ? s : 4'b0000);
    check_strobe("wport.data_we[1]", wport.data_we[1], way[1] ? s : 4'b0000);
    check_dram("wport.data_waddr", wport.data_waddr, a[11:2]);
    check_word("wport.data_wdata", wport.data_wdata, d);
    if (bus_req.valid) report_failure("hit store raised a bus request");
    @(posedge clk);
    #1 pipe_req.hit_write = 1'b0;
  endtask

  task automatic push_store(lsu_pkg::addr_t a, lsu_pkg::word_t d, lsu_pkg::strobe_t s,
                            lsu_pkg::size_t sz);
    @(posedge clk);
    #1;
    pipe_req.uncached_write = 1'b1;
    pipe_req.addr           = a;
    pipe_req.wdata          = d;
    pipe_req.wstrobe        = s;
    pipe_req.size           = sz;
    do @(negedge clk); while (!resp.wr_ready);
    @(posedge clk);
    #1 pipe_req.uncached_write = 1'b0;
  endtask

  // holds the request until op_done
  task automatic miss_op(lsu_pkg::addr_t a, logic uncached, lsu_pkg::size_t sz,
                         lsu_pkg::tag_t t0, lsu_pkg::tag_t t1);
    @(posedge clk);
    #1;
    pipe_req.addr         = a;
    pipe_req.size         = sz;
    pipe_req.tag_rdata[0] = t0;
    pipe_req.tag_rdata[1] = t1;
    if (uncached) pipe_req.uncached_read = 1'b1;
    else pipe_req.refill_req = 1'b1;
    do @(negedge clk); while (!resp.op_done);
    @(posedge clk);
    #1;
    pipe_req.refill_req    = 1'b0;
    pipe_req.uncached_read = 1'b0;
  endtask

  task automatic check_store_txn(bus_txn_t t, lsu_pkg::addr_t a, lsu_pkg::word_t d,
                                 lsu_pkg::strobe_t s, lsu_pkg::size_t sz);
    if (!t.write || t.burst != lsu_pkg::BURST_ONE || t.cached) begin
      report_failure("uncached store is not a single-beat uncached write");
    end
    check_addr("bus_req.addr", t.addr, a);
    check_size("bus_req.data_size", t.size, sz);
    check_strobe("bus_req.data_strobe", t.strobe, s);
    check_word("bus_req.w_data", t.data[0], d);
    if (!t.last_ok) report_failure("data_last missing on the store beat");
  endtask

  task automatic check_refill(lsu_pkg::addr_t a, int way, int idx);
    lsu_pkg::addr_t base;
    lsu_pkg::way_mask_t mask;
    bus_txn_t t;
    base = {a[31:4], 4'b0000};
    mask = 2'b01 << way;
    check_count("bus transfers", bus_log.size(), idx + 1);
    if (bus_log.size() > idx) begin
      t = bus_log[idx];
      if (t.write || t.burst != lsu_pkg::BURST_LINE || !t.cached) begin
        report_failure("refill is not a cached four-beat read");
      end
      check_addr("bus_req.addr", t.addr, base);
    end
    check_count("data RAM writes", dwr_log.size(), 4);
    for (int i = 0; i < dwr_log.size() && i < 4; i++) begin
      check_mask("data_we way", dwr_log[i].way, mask);
      check_dram("wport.data_waddr", dwr_log[i].waddr, {a[11:4], 2'(i)});
      check_word("wport.data_wdata", dwr_log[i].wdata, (base + 32'(4 * i)) ^ RDATA_K);
      check_strobe("wport.data_we", dwr_log[i].strobe, 4'hf);
    end
    check_count("read_ready pulses", rr_log.size(), 1);
    if (rr_log.size() > 0) check_word("resp.rdata", rr_log[0], {a[31:2], 2'b00} ^ RDATA_K);
    check_count("tag writes", tag_log.size(), 1);
    if (tag_log.size() > 0) begin
      check_mask("wport.tag_we", tag_log[0].we, mask);
      check_index("wport.tag_waddr", tag_log[0].waddr, a[11:4]);
      check_tag("wport.tag_wdata", tag_log[0].wdata, {1'b1, a[31:12]});
    end
  endtask

  task automatic test_hit_store();
    int e0;
    e0 = errors;
    clear_logs();
    hit_store(32'h0000_1238, 32'hcafe_f00d, 4'b0110, 2'b01);
    repeat (4) @(negedge clk);
    check_count("bus transfers", bus_log.size(), 0);
    finish_test("hit store", e0);
  endtask

  task automatic test_uncached_stores();
    int e0;
    e0 = errors;
    clear_logs();
    push_store(32'h8000_0010, 32'h1111_2222, 4'b1111, 2'd2);
    push_store(32'h8000_0022, 32'h3333_4444, 4'b1100, 2'd1);
    push_store(32'h8000_0031, 32'h5555_6666, 4'b0010, 2'd0);
    while (bus_log.size() < 3) @(negedge clk);
    check_store_txn(bus_log[0], 32'h8000_0010, 32'h1111_2222, 4'b1111, 2'd2);
    check_store_txn(bus_log[1], 32'h8000_0022, 32'h3333_4444, 4'b1100, 2'd1);
    check_store_txn(bus_log[2], 32'h8000_0031, 32'h5555_6666, 4'b0010, 2'd0);
    finish_test("uncached stores", e0);
  endtask

  task automatic test_first_refill();
    int e0;
    e0 = errors;
    clear_logs();
    miss_op(32'h1234_5678, 1'b0, 2'd2, {1'b1, 20'h00abc}, {1'b1, 20'h00def});
    check_refill(32'h1234_5678, 1, 0);
    check_count("data RAM takeover cycles", take_log.size(), 0);
    finish_test("first refill", e0);
  endtask

  task automatic test_dirty_writeback();
    int e0;
    bus_txn_t t;
    lsu_pkg::addr_t a;
    e0 = errors;
    a = 32'h7777_7a44;
    hit_store(32'h0000_3a40, 32'h0bad_beef, 4'b0011, 2'b01);
    clear_logs();
    miss_op(a, 1'b0, 2'd2, {1'b1, 20'h00003}, {1'b0, 20'h00000});
    if (bus_log.size() > 0) begin
      t = bus_log[0];
      if (!t.write || t.burst != lsu_pkg::BURST_LINE || !t.cached) begin
        report_failure("writeback is not a cached four-beat write");
      end
      check_addr("bus_req.addr", t.addr, {20'h00003, a[11:4], 4'b0000});
      for (int i = 0; i < 4; i++) begin
        check_word("bus_req.w_data", t.data[i], 32'({a[11:4], 2'(i)}) ^ WAY0_K);
      end
      if (!t.last_ok) report_failure("data_last not on the fourth writeback beat");
    end
    // writeback reads words 0 to 3 of the victim line
    check_count("data RAM takeover cycles", take_log.size(), 4);
    for (int i = 0; i < take_log.size() && i < 4; i++) begin
      check_dram("resp.data_raddr", take_log[i], {a[11:4], 2'(i)});
    end
    check_refill(a, 0, 1);
    finish_test("dirty writeback", e0);
  endtask

  task automatic test_uncached_read();
    int e0;
    bus_txn_t t;
    lsu_pkg::addr_t a;
    e0 = errors;
    a = 32'h9000_0106;
    clear_logs();
    miss_op(a, 1'b1, 2'd1, '0, '0);
    check_count("bus transfers", bus_log.size(), 1);
    if (bus_log.size() > 0) begin
      t = bus_log[0];
      if (t.write || t.burst != lsu_pkg::BURST_ONE || t.cached) begin
        report_failure("uncached read is not a single-beat uncached read");
      end
      check_addr("bus_req.addr", t.addr, a);
      check_size("bus_req.data_size", t.size, 2'd1);
    end
    check_count("read_ready pulses", rr_log.size(), 1);
    if (rr_log.size() > 0) check_word("resp.rdata", rr_log[0], a ^ RDATA_K);
    check_count("data RAM writes", dwr_log.size(), 0);
    check_count("tag writes", tag_log.size(), 0);
    check_count("data RAM takeover cycles", take_log.size(), 0);
    finish_test("uncached read", e0);
  endtask

  task automatic test_store_before_refill();
    int e0;
    e0 = errors;
    clear_logs();
    push_store(32'h8000_0040, 32'h7777_8888, 4'b1111, 2'd2);
    miss_op(32'h4444_5504, 1'b0, 2'd2, {1'b0, 20'h0}, {1'b1, 20'h00123});
    if (bus_log.size() > 0) begin
      check_store_txn(bus_log[0], 32'h8000_0040, 32'h7777_8888, 4'b1111, 2'd2);
    end
    check_refill(32'h4444_5504, 1, 1);
    finish_test("store before refill", e0);
  endtask

  initial begin : main
    void'($urandom(32'he648));
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    pipe_req     = '0;
    model_rdata  = '0;
    rst_n        = 1'b0;
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;
    test_hit_store();
    test_uncached_stores();
    test_first_refill();
    test_dirty_writeback();
    test_uncached_read();
    test_store_before_refill();
    repeat (5) @(posedge clk);
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: sim.f
design/lsu_pkg.sv
design/dirty_ram.sv
design/uncached_write_buffer.sv
design/miss_handler.sv
design/cache_write_port.sv
design/bus_request_mux.sv
design/lsu_wport.sv
testbench/tb_lsu_wport.sv

// File: run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module tb_lsu_wport -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qF '*** FAILED ***' sim.log; then
  exit 1
fi
exit 0
